// File: rtl/lockstep_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Constants and types shared by the lockstep checker and its sum core.
// Bus and core signal groups, the read codeword view and the masks of
// the 39/32 inverted SECDED code. Import with lockstep_pkg::*.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package lockstep_pkg;

  // Shadow core lag, plus one cycle for its output register
  localparam int unsigned LOCKSTEP_OFFSET = 2;
  localparam int unsigned OUTPUTS_OFFSET  = LOCKSTEP_OFFSET + 1;
  localparam int unsigned OFFSET_W        = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  localparam int unsigned DATA_W = 32;
  localparam int unsigned INTG_W = 7;
  localparam int unsigned CODE_W = DATA_W + INTG_W;

  localparam logic [DATA_W-1:0] BASE_ADDR = 32'h0000_1000;
  localparam logic [DATA_W-1:0] ADDR_STEP = 32'd4;

  // Check bit k is the parity of the data bits in mask k
  localparam logic [INTG_W-1:0][DATA_W-1:0] SECDED_MASKS = {
    32'h9850_5586,
    32'h2DCC_624C,
    32'hC2C1_323B,
    32'h3123_4ED1,
    32'h413D_89AA,
    32'hDEBA_8050,
    32'h2606_BD25
  };

  // Inverted code so that all-zero words are not valid
  localparam logic [INTG_W-1:0] SECDED_INV = 7'h2A;

  typedef struct packed {
    logic              fetch_enable;
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } core_in_t;

  typedef struct packed {
    logic              req;
    logic              busy;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] sum;
  } core_out_t;

  typedef struct packed {
    logic [INTG_W-1:0] intg;
    logic [DATA_W-1:0] data;
  } bus_code_t;

  // Raw view feeds the syndrome, field view is for building the word
  typedef union packed {
    logic [CODE_W-1:0] raw;
    bus_code_t         fields;
  } bus_code_u;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_REQ,
    CORE_ACK_LOW
  } core_state_e;

endpackage

`default_nettype wire

// File: rtl/lockstep_reset_seq.sv
////////////////////////////////////////////////////////////////////////////
// Reset sequencer for the shadow core. Releases the shadow reset
// LOCKSTEP_OFFSET cycles after the main reset and enables the output
// comparison one cycle later.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lockstep_reset_seq import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  logic [OFFSET_W-1:0] cnt_d;
  logic [OFFSET_W-1:0] cnt_q;
  logic                release_d;
  logic                release_q;
  logic                cmp_en_q;

  // Counter saturates at the last count
  assign release_d = (cnt_q == OFFSET_W'(LOCKSTEP_OFFSET - 1));
  assign cnt_d     = release_d ? cnt_q : cnt_q + OFFSET_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      release_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      release_q <= release_d;
      cmp_en_q  <= release_q;
    end
  end

  assign shadow_rst_no = release_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

`default_nettype wire

// File: rtl/lockstep_delay_line.sv
////////////////////////////////////////////////////////////////////////////
// Fixed delay for a packed vector. A value on data_i shows on first_o
// after one clock edge and on last_o after Depth edges.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lockstep_delay_line #(
  parameter int unsigned Width = 1,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] first_o,
  output logic [Width-1:0] last_o
);

  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Stage 0 is one cycle old, the top stage Depth cycles old
  assign first_o = stage_q[0];
  assign last_o  = stage_q[Depth-1];

endmodule

`default_nettype wire

// File: rtl/secded_39_32_chk.sv
////////////////////////////////////////////////////////////////////////////
// Integrity check of read data with the 39/32 inverted SECDED code.
// Detection only. bus_i is already one cycle old, so the check bits are
// registered here to line up with it. err_o flags bad accepted words.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module secded_39_32_chk import lockstep_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  core_in_t          bus_i,
  input  logic [INTG_W-1:0] intg_i,
  output logic              err_o
);

  logic [INTG_W-1:0] intg_q;
  bus_code_u         code;
  logic [INTG_W-1:0] syndrome;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intg_q <= '0;
    end else begin
      intg_q <= intg_i;
    end
  end

  always_comb begin
    code.fields.intg = intg_q;
    code.fields.data = bus_i.rdata;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Syndrome
  ////////////////////////////////////////////////////////////////////////////

  // Each syndrome bit covers its data mask plus its own check bit
  always_comb begin
    for (int unsigned k = 0; k < INTG_W; k++) begin
      syndrome[k] = ^(code.raw & {INTG_W'(1) << k, SECDED_MASKS[k]}) ^ SECDED_INV[k];
    end
  end

  // Only words taken with ack count
  assign err_o = bus_i.ack & (|syndrome);

endmodule

`default_nettype wire

// File: rtl/sum_core.sv
////////////////////////////////////////////////////////////////////////////
// Small bus reader under lockstep protection. Reads words over a
// four-phase req/ack bus from BASE_ADDR upward and keeps a running sum.
// One copy runs outside the checker, a second one inside as shadow.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sum_core import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_in_t  core_i,
  output core_out_t core_o
);

  core_state_e state_d;
  core_state_e state_q;
  core_out_t   out_d;
  core_out_t   out_q;

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    out_d   = out_q;
    case (state_q)
      CORE_IDLE: begin
        if (core_i.fetch_enable) begin
          out_d.req  = 1'b1;
          out_d.busy = 1'b1;
          state_d    = CORE_REQ;
        end
      end
      CORE_REQ: begin
        // Hold req and addr until ack arrives
        if (core_i.ack) begin
          out_d.req = 1'b0;
          out_d.sum = out_q.sum + core_i.rdata;
          state_d   = CORE_ACK_LOW;
        end
      end
      CORE_ACK_LOW: begin
        if (!core_i.ack) begin
          out_d.addr = out_q.addr + ADDR_STEP;
          if (core_i.fetch_enable) begin
            out_d.req = 1'b1;
            state_d   = CORE_REQ;
          end else begin
            out_d.busy = 1'b0;
            state_d    = CORE_IDLE;
          end
        end
      end
      default: begin
        state_d = CORE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= CORE_IDLE;
      out_q.req  <= 1'b0;
      out_q.busy <= 1'b0;
      out_q.addr <= BASE_ADDR;
      out_q.sum  <= '0;
    end else begin
      state_q <= state_d;
      out_q   <= out_d;
    end
  end

  assign core_o = out_q;

endmodule

`default_nettype wire

// File: rtl/lockstep_compare.sv
////////////////////////////////////////////////////////////////////////////
// Output comparison. Registers the shadow core outputs, compares them
// with the delayed main core outputs and merges in integrity errors.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lockstep_compare import lockstep_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cmp_en_i,
  input  core_out_t shadow_out_i,
  input  core_out_t main_out_i,
  input  logic      intg_err_i,
  output logic      alert_major_o
);

  core_out_t shadow_q;
  logic      mismatch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_out_i;
    end
  end

  // Copies only count once the shadow core is out of reset
  assign mismatch = cmp_en_i & (shadow_q != main_out_i);

  assign alert_major_o = mismatch | intg_err_i;

endmodule

`default_nettype wire

// File: rtl/lockstep_top.sv
////////////////////////////////////////////////////////////////////////////
// Lockstep checker for sum_core. Takes the main core's bus inputs and
// outputs, runs a delayed shadow copy, compares both copies and checks
// read data integrity. Any fault raises alert_major_o.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lockstep_top import lockstep_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  core_in_t          main_in_i,
  input  logic [INTG_W-1:0] rdata_intg_i,
  input  core_out_t         main_out_i,
  output logic              alert_major_o
);

  logic      shadow_rst_n;
  logic      cmp_en;
  logic      intg_err;
  core_in_t  in_first;
  core_in_t  in_last;
  core_out_t main_out_dly;
  core_out_t shadow_out;

  lockstep_reset_seq u_reset_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  // Bus inputs for the shadow core and the checker
  lockstep_delay_line #(
    .Width ($bits(core_in_t)),
    .Depth (LOCKSTEP_OFFSET)
  ) u_in_delay (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (main_in_i),
    .first_o (in_first),
    .last_o  (in_last)
  );

  // Main outputs, lined up with the registered shadow outputs
  lockstep_delay_line #(
    .Width ($bits(core_out_t)),
    .Depth (OUTPUTS_OFFSET)
  ) u_out_delay (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (main_out_i),
    .first_o (),
    .last_o  (main_out_dly)
  );

  sum_core u_shadow_core (
    .clk_i  (clk_i),
    .rst_ni (shadow_rst_n),
    .core_i (in_last),
    .core_o (shadow_out)
  );

  secded_39_32_chk u_intg_chk (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus_i  (in_first),
    .intg_i (rdata_intg_i),
    .err_o  (intg_err)
  );

  lockstep_compare u_compare (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmp_en_i      (cmp_en),
    .shadow_out_i  (shadow_out),
    .main_out_i    (main_out_dly),
    .intg_err_i    (intg_err),
    .alert_major_o (alert_major_o)
  );

endmodule

`default_nettype wire

// File: tb/lockstep_sva.sv
////////////////////////////////////////////////////////////////////////////
// Bus rule assertions for sum_core. Bound to every instance of the core,
// so the shadow copy inside the lockstep checker is covered.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lockstep_sva import lockstep_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input core_in_t  core_i,
  input core_out_t core_o
);

  // Request waits for ack with a stable address
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_o.req && !core_i.ack) |=> (core_o.req && $stable(core_o.addr)))
    else $error("req or addr changed before ack");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_o.req && core_i.ack) |=> !core_o.req)
    else $error("req still high after ack");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_o.req |-> core_o.busy)
    else $error("req high while not busy");

endmodule

bind sum_core lockstep_sva u_sva (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .core_i (core_i),
  .core_o (core_o)
);

`default_nettype wire

// File: tb/lockstep_monitor.sv
////////////////////////////////////////////////////////////////////////////
// Alert checker. Predicts alert_major_o from the injected faults and
// compares it with the DUT in the middle of every cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lockstep_monitor import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flip_i,
  input  logic bad_code_i,
  input  logic alert_i,
  output int   err_count_o
);

  logic [OUTPUTS_OFFSET-1:0] flip_hist = '0;
  logic                      bad_hist  = 1'b0;
  logic                      expected;
  int                        errors    = 0;

  // Output flips show after OUTPUTS_OFFSET cycles, bad words after one
  always @(negedge clk_i) begin
    expected = flip_hist[OUTPUTS_OFFSET-1] | bad_hist;
    if (alert_i !== expected) begin
      $display("mismatch at %0t: alert_major_o expected %0b, actual %0b",
               $time, expected, alert_i);
      errors = errors + 1;
    end
    if (!rst_ni) begin
      flip_hist = '0;
      bad_hist  = 1'b0;
    end else begin
      flip_hist = {flip_hist[OUTPUTS_OFFSET-2:0], flip_i};
      bad_hist  = bad_code_i;
    end
  end

  assign err_count_o = errors;

endmodule

`default_nettype wire

// File: tb/tb_lockstep.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the lockstep checker. Models the main core, answers its
// reads with random latency and data, injects output and codeword faults
// and lets lockstep_monitor check the alert.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_lockstep import lockstep_pkg::*; ();

  localparam int MAX_CYCLES = 2000;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  core_in_t          main_in;
  logic [INTG_W-1:0] rdata_intg;
  core_out_t         main_out;
  logic              alert_major;
  core_out_t         model_q;
  core_out_t         main_out_q;
  core_out_t         flip_mask;
  int                model_state;
  int                next_state;
  logic              corrupt_word;
  logic              bad_code;
  int                seed;
  int                cycles = 0;
  int                err_count;
  int                errs_before = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  always #10 clk_i = ~clk_i;

  lockstep_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .main_in_i     (main_in),
    .rdata_intg_i  (rdata_intg),
    .main_out_i    (main_out),
    .alert_major_o (alert_major)
  );

  lockstep_monitor u_monitor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flip_i      (|flip_mask),
    .bad_code_i  (bad_code),
    .alert_i     (alert_major),
    .err_count_o (err_count)
  );

  function automatic logic [INTG_W-1:0] encode_intg(input logic [DATA_W-1:0] d);
    logic [INTG_W-1:0] c;
    for (int k = 0; k < INTG_W; k++) begin
      c[k] = (^(d & SECDED_MASKS[k])) ^ SECDED_INV[k];
    end
    return c;
  endfunction

  function automatic core_out_t idle_out();
    core_out_t o;
    o.req  = 1'b0;
    o.busy = 1'b0;
    o.addr = BASE_ADDR;
    o.sum  = '0;
    return o;
  endfunction

  // One clock of the four-phase reader, states idle, request, ack low
  function automatic core_out_t step_core(input core_out_t o, input core_in_t i,
                                          input int st, output int st_n);
    core_out_t n;
    n    = o;
    st_n = st;
    if (st == 0 && i.fetch_enable) begin
      n.req  = 1'b1;
      n.busy = 1'b1;
      st_n   = 1;
    end else if (st == 1 && i.ack) begin
      n.req = 1'b0;
      n.sum = o.sum + i.rdata;
      st_n  = 2;
    end else if (st == 2 && !i.ack) begin
      n.addr = o.addr + ADDR_STEP;
      if (i.fetch_enable) begin
        n.req = 1'b1;
        st_n  = 1;
      end else begin
        n.busy = 1'b0;
        st_n   = 0;
      end
    end
    return n;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      model_q     <= idle_out();
      model_state <= 0;
    end else begin
      model_q     <= step_core(model_q, main_in, model_state, next_state);
      model_state <= next_state;
    end
  end

  // Main core outputs reach the DUT a little after the edge
  always @(posedge clk_i) begin
    #2;
    main_out_q = model_q;
  end

  assign main_out = main_out_q ^ flip_mask;
  assign bad_code = corrupt_word & main_in.ack;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // Kind 0 clean, 1 data bit, 2 check bit, 3 two data bits
  task automatic read_word(input int kind, input bit hold_req);
    int                lat;
    int                b;
    logic [DATA_W-1:0] d;
    logic [INTG_W-1:0] c;
    core_out_t         req_mask;
    while (!model_q.req) next_cycle();
    lat = $random(seed) & 3;
    wait_cycles(lat);
    d = $random(seed);
    c = encode_intg(d);
    b = $random(seed) & 31;
    case (kind)
      1: d = d ^ (32'd1 << b);
      2: c = c ^ (7'd1 << (b % 7));
      3: d = d ^ (32'd1 << b) ^ (32'd1 << ((b + 1) % 32));
    endcase
    main_in.rdata = d;
    rdata_intg    = c;
    corrupt_word  = (kind != 0);
    main_in.ack   = 1'b1;
    next_cycle();
    while (model_q.req) next_cycle();
    if (hold_req) begin
      req_mask     = '0;
      req_mask.req = 1'b1;
      flip_mask    = req_mask;
    end
    main_in.ack  = 1'b0;
    corrupt_word = 1'b0;
    next_cycle();
    flip_mask = '0;
  endtask

  task automatic flip_sum();
    core_out_t m;
    int        b;
    b     = $random(seed) & 31;
    m     = '0;
    m.sum = 32'd1 << b;
    next_cycle();
    flip_mask = m;
    next_cycle();
    flip_mask = '0;
  endtask

  task automatic finish_test(input string name);
    wait_cycles(OUTPUTS_OFFSET + 2);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
      $display("test %s: failed, %0d mismatches", name, err_count - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
    errs_before = err_count;
  endtask

  initial begin
    seed         = 32'hf695_9995;
    rst_ni       = 1'b0;
    main_in      = '0;
    rdata_intg   = '0;
    flip_mask    = '0;
    corrupt_word = 1'b0;
    main_out_q   = idle_out();
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    wait_cycles(8);
    finish_test("reset sequence");

    main_in.fetch_enable = 1'b1;
    repeat (30) read_word(0, 1'b0);
    finish_test("clean reads");

    flip_sum();
    finish_test("sum bit flip");

    read_word(0, 1'b1);
    finish_test("req held too long");

    read_word(1, 1'b0);
    read_word(2, 1'b0);
    finish_test("single-bit errors");

    read_word(3, 1'b0);
    read_word(0, 1'b0);
    finish_test("double-bit error");

    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
rtl/lockstep_pkg.sv
rtl/lockstep_reset_seq.sv
rtl/lockstep_delay_line.sv
rtl/secded_39_32_chk.sv
rtl/sum_core.sv
rtl/lockstep_compare.sv
rtl/lockstep_top.sv
tb/lockstep_sva.sv
tb/lockstep_monitor.sv
tb/tb_lockstep.sv

// File: Makefile
# Verilator build and run of the lockstep checker testbench

VERILATOR ?= verilator
TOP       ?= tb_lockstep
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(SIM): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
